// ==== cpu_pkg.sv ====
package cpu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [31:0] word_t;
  typedef logic [3:0]  reg_addr_t;
  typedef logic [15:0] pc_t;        // Instruction word address
  typedef logic [15:0] imm_t;

  localparam int NUM_REGS = 16;

  // Opcodes above OP_BZ decode as NOP
  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_ORR  = 4'd4,
    OP_ADDI = 4'd5,
    OP_LDR  = 4'd6,
    OP_STR  = 4'd7,
    OP_B    = 4'd8,
    OP_BZ   = 4'd9
  } opcode_e;

  // Instruction field positions
  localparam int OPC_HI = 31;
  localparam int OPC_LO = 28;
  localparam int RD_HI  = 27;
  localparam int RD_LO  = 24;
  localparam int RN_HI  = 23;
  localparam int RN_LO  = 20;
  localparam int RM_HI  = 19;
  localparam int RM_LO  = 16;
  localparam int IMM_HI = 15;
  localparam int IMM_LO = 0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage records
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic  valid;
    pc_t   pc;
    word_t instr;
  } fetch_t;

  typedef struct packed {
    logic      valid;
    opcode_e   opcode;
    reg_addr_t rd;
    word_t     rn_val;
    word_t     rm_val;       // Store data for STR
    imm_t      imm;
  } decode_t;

  typedef struct packed {
    logic      valid;
    opcode_e   opcode;
    reg_addr_t rd;
    word_t     result;       // ALU value or memory address
    word_t     store_data;
  } exec_t;

  typedef struct packed {
    logic      valid;
    logic      reg_we;
    reg_addr_t rd;
    word_t     data;
    logic      store;
    word_t     mem_addr;
  } commit_t;

  // Pending register write of an in-flight instruction
  typedef struct packed {
    logic      we;
    reg_addr_t rd;
  } hazard_t;

  function automatic logic writes_reg(opcode_e op);
    return op inside {OP_ADD, OP_SUB, OP_AND, OP_ORR, OP_ADDI, OP_LDR};
  endfunction

endpackage

// ==== fetch.sv ====
module fetch (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            stall_i,
  input  logic            branch_i,
  input  cpu_pkg::pc_t    branch_addr_i,
  input  cpu_pkg::word_t  imem_data_i,
  output cpu_pkg::pc_t    imem_addr_o,
  output cpu_pkg::fetch_t fetch_o
);
  import cpu_pkg::*;

  pc_t pc_q;
  pc_t pc_next;
  logic load;

  assign imem_addr_o = pc_q;         // Memory answers in the same cycle

  // Redirect wins over a stall
  always_comb begin
    load    = 1'b0;
    pc_next = pc_q;
    if (branch_i) begin
      pc_next = branch_addr_i;
    end else if (!stall_i) begin
      pc_next = pc_q + pc_t'(1);
      load    = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_next;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      fetch_o.pc    <= pc_q;
      fetch_o.instr <= imem_data_i;
    end
    if (rst_i || branch_i) begin
      fetch_o.valid <= 1'b0;           // Kill the wrong-path instruction
    end else if (load) begin
      fetch_o.valid <= 1'b1;
    end
  end

endmodule

// ==== decode_reg_r.sv ====
module decode_reg_r (
  input  logic               clk_i,
  input  logic               rst_i,
  input  cpu_pkg::fetch_t    fetch_i,
  input  logic               flush_i,
  input  cpu_pkg::hazard_t   ex_hz_i,
  input  cpu_pkg::hazard_t   mem_hz_i,
  input  logic               wb_we_i,
  input  cpu_pkg::reg_addr_t wb_addr_i,
  input  cpu_pkg::word_t     wb_data_i,
  output logic               stall_o,
  output cpu_pkg::decode_t   decode_o
);
  import cpu_pkg::*;

  word_t     regs [NUM_REGS];
  opcode_e   op;
  reg_addr_t rd;
  reg_addr_t rn;
  reg_addr_t rm;
  reg_addr_t rs;
  imm_t      imm;
  logic      use_rn;
  logic      use_rs;
  word_t     rn_val;
  word_t     rs_val;

  function automatic logic hits(hazard_t hz, logic use_a, reg_addr_t a,
                                logic use_b, reg_addr_t b);
    return hz.we && ((use_a && hz.rd == a) || (use_b && hz.rd == b));
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Field decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    if (fetch_i.instr[OPC_HI:OPC_LO] > 4'(OP_BZ)) begin
      op = OP_NOP;
    end else begin
      op = opcode_e'(fetch_i.instr[OPC_HI:OPC_LO]);
    end
  end

  assign rd  = fetch_i.instr[RD_HI:RD_LO];
  assign rn  = fetch_i.instr[RN_HI:RN_LO];
  assign rm  = fetch_i.instr[RM_HI:RM_LO];
  assign imm = fetch_i.instr[IMM_HI:IMM_LO];
  assign rs  = (op == OP_STR) ? rd : rm;   // STR sends rd as store data

  assign use_rn = op inside {OP_ADD, OP_SUB, OP_AND, OP_ORR, OP_ADDI,
                             OP_LDR, OP_STR, OP_BZ};
  assign use_rs = op inside {OP_ADD, OP_SUB, OP_AND, OP_ORR, OP_STR};

  // Read ports with write-back bypass
  assign rn_val = (wb_we_i && wb_addr_i == rn) ? wb_data_i : regs[rn];
  assign rs_val = (wb_we_i && wb_addr_i == rs) ? wb_data_i : regs[rs];

  // A flushed instruction never has to wait
  assign stall_o = fetch_i.valid && !flush_i &&
                   (hits(ex_hz_i, use_rn, rn, use_rs, rs) ||
                    hits(mem_hz_i, use_rn, rn, use_rs, rs));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we_i) begin
      regs[wb_addr_i] <= wb_data_i;
    end
  end

  // Decode register, bubble on stall
  always_ff @(posedge clk_i) begin
    decode_o.opcode <= op;
    decode_o.rd     <= rd;
    decode_o.rn_val <= rn_val;
    decode_o.rm_val <= rs_val;
    decode_o.imm    <= imm;
    if (rst_i) begin
      decode_o.valid <= 1'b0;
    end else begin
      decode_o.valid <= fetch_i.valid && !flush_i && !stall_o;
    end
  end

endmodule

// ==== execute.sv ====
module execute (
  input  logic             clk_i,
  input  logic             rst_i,
  input  cpu_pkg::decode_t decode_i,
  output cpu_pkg::exec_t   exec_o,
  output cpu_pkg::hazard_t hz_o,
  output logic             branch_o,
  output cpu_pkg::pc_t     branch_addr_o
);
  import cpu_pkg::*;

  word_t imm_ext;
  word_t alu;
  logic  rn_zero;

  assign imm_ext = word_t'(decode_i.imm);     // Zero extend
  assign rn_zero = (decode_i.rn_val == '0);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ALU and address generation
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    case (decode_i.opcode)
      OP_ADD: begin
        alu = decode_i.rn_val + decode_i.rm_val;
      end
      OP_SUB: begin
        alu = decode_i.rn_val - decode_i.rm_val;
      end
      OP_AND: begin
        alu = decode_i.rn_val & decode_i.rm_val;
      end
      OP_ORR: begin
        alu = decode_i.rn_val | decode_i.rm_val;
      end
      OP_ADDI, OP_LDR, OP_STR: begin
        alu = decode_i.rn_val + imm_ext;      // Sum or memory address
      end
      default: begin
        alu = '0;
      end
    endcase
  end

  // Resolved from the stage input so fetch turns around next cycle
  assign branch_o = decode_i.valid &&
                    (decode_i.opcode == OP_B || (decode_i.opcode == OP_BZ && rn_zero));
  assign branch_addr_o = pc_t'(decode_i.imm);

  assign hz_o = '{we: decode_i.valid && writes_reg(decode_i.opcode), rd: decode_i.rd};

  always_ff @(posedge clk_i) begin
    exec_o.opcode     <= decode_i.opcode;
    exec_o.rd         <= decode_i.rd;
    exec_o.result     <= alu;
    exec_o.store_data <= decode_i.rm_val;
    if (rst_i) begin
      exec_o.valid <= 1'b0;
    end else begin
      exec_o.valid <= decode_i.valid;
    end
  end

endmodule

// ==== mem.sv ====
module mem #(
  parameter int DMEM_WORDS = 64
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  cpu_pkg::exec_t     exec_i,
  output cpu_pkg::hazard_t   hz_o,
  output logic               wb_we_o,
  output cpu_pkg::reg_addr_t wb_addr_o,
  output cpu_pkg::word_t     wb_data_o,
  output cpu_pkg::commit_t   commit_o
);
  import cpu_pkg::*;

  localparam int IDX_W = $clog2(DMEM_WORDS);

  word_t            dmem [DMEM_WORDS];
  logic [IDX_W-1:0] idx;
  logic             is_ld;
  logic             is_st;
  logic             we;
  word_t            wb_val;

  assign idx   = IDX_W'(exec_i.result % DMEM_WORDS);   // Word address wraps
  assign is_ld = exec_i.opcode == OP_LDR;
  assign is_st = exec_i.valid && exec_i.opcode == OP_STR;
  assign we    = exec_i.valid && writes_reg(exec_i.opcode);

  assign wb_val = is_ld ? dmem[idx] : exec_i.result;  // Asynchronous load

  assign hz_o = '{we: we, rd: exec_i.rd};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else if (is_st) begin
      dmem[idx] <= exec_i.store_data;
    end
  end

  // Commit record doubles as the write-back register
  always_ff @(posedge clk_i) begin
    commit_o.rd       <= exec_i.rd;
    commit_o.data     <= is_st ? exec_i.store_data : wb_val;
    commit_o.mem_addr <= (is_ld || exec_i.opcode == OP_STR) ? exec_i.result : '0;
    if (rst_i) begin
      commit_o.valid  <= 1'b0;
      commit_o.reg_we <= 1'b0;
      commit_o.store  <= 1'b0;
    end else begin
      commit_o.valid  <= we || is_st;   // NOP and branches leave no record
      commit_o.reg_we <= we;
      commit_o.store  <= is_st;
    end
  end

  assign wb_we_o   = commit_o.reg_we;
  assign wb_addr_o = commit_o.rd;
  assign wb_data_o = commit_o.data;

endmodule

// ==== cpu.sv ====
module cpu #(
  parameter int DMEM_WORDS = 64
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  cpu_pkg::word_t   imem_data_i,
  output cpu_pkg::pc_t     imem_addr_o,
  output cpu_pkg::commit_t commit_o
);
  import cpu_pkg::*;

  fetch_t    fetch_s;
  decode_t   decode_s;
  exec_t     exec_s;
  hazard_t   ex_hz;
  hazard_t   mem_hz;
  logic      stall;
  logic      branch;
  logic      flush;
  pc_t       branch_addr;
  logic      wb_we;
  reg_addr_t wb_addr;
  word_t     wb_data;

  assign flush = branch;            // Taken branch kills the decode input

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pipeline stages
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  fetch fetch_module (
      .clk_i( clk_i )
    , .rst_i( rst_i )
    , .stall_i( stall )
    , .branch_i( branch )
    , .branch_addr_i( branch_addr )
    , .imem_data_i( imem_data_i )
    , .imem_addr_o( imem_addr_o )
    , .fetch_o( fetch_s )
  );

  decode_reg_r decode_module (
      .clk_i( clk_i )
    , .rst_i( rst_i )
    , .fetch_i( fetch_s )
    , .flush_i( flush )
    , .ex_hz_i( ex_hz )
    , .mem_hz_i( mem_hz )
    , .wb_we_i( wb_we )
    , .wb_addr_i( wb_addr )
    , .wb_data_i( wb_data )
    , .stall_o( stall )
    , .decode_o( decode_s )
  );

  execute execute_module (
      .clk_i( clk_i )
    , .rst_i( rst_i )
    , .decode_i( decode_s )
    , .exec_o( exec_s )
    , .hz_o( ex_hz )
    , .branch_o( branch )
    , .branch_addr_o( branch_addr )
  );

  mem #(
    .DMEM_WORDS( DMEM_WORDS )
  ) memory_module (
      .clk_i( clk_i )
    , .rst_i( rst_i )
    , .exec_i( exec_s )
    , .hz_o( mem_hz )
    , .wb_we_o( wb_we )
    , .wb_addr_o( wb_addr )
    , .wb_data_o( wb_data )
    , .commit_o( commit_o )
  );

endmodule

// ==== cpu_assert.sv ====
module cpu_assert (
  input logic             clk_i,
  input logic             rst_i,
  input cpu_pkg::commit_t commit_i,
  input logic             branch_i,
  input logic             fetch_valid_i,
  input logic             stall_i,
  input cpu_pkg::pc_t     pc_i
);

  commit_clear_a: assert property (@(posedge clk_i) rst_i |=> !commit_i.valid)
    else $error("commit valid set in the cycle after reset");

  // Wrong-path instruction must be gone
  branch_kill_a: assert property (@(posedge clk_i) disable iff (rst_i)
    branch_i |=> !fetch_valid_i)
    else $error("fetch register still valid after a taken branch");

  stall_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    stall_i |=> $stable(pc_i))
    else $error("PC moved during a decode stall");

endmodule

bind cpu cpu_assert assert_i (
    .clk_i( clk_i )
  , .rst_i( rst_i )
  , .commit_i( commit_o )
  , .branch_i( branch )
  , .fetch_valid_i( fetch_s.valid )
  , .stall_i( stall )
  , .pc_i( imem_addr_o )
);

// ==== cpu_tb.sv ====
module cpu_tb;
  import cpu_pkg::*;

  localparam int PROG_LEN     = 200;
  localparam int DMEM_WORDS   = 64;
  localparam int RESET_CYCLES = 5;

  logic    clk;
  logic    rst;
  word_t   imem_data;
  pc_t     imem_addr;
  commit_t commit;

  word_t   prog [PROG_LEN];
  commit_t exp_q [$];
  commit_t exp_rec;
  int      n_exp;
  int      n_seen;
  integer  seed;

  cpu #(
    .DMEM_WORDS( DMEM_WORDS )
  ) dut_i (
      .clk_i( clk )
    , .rst_i( rst )
    , .imem_data_i( imem_data )
    , .imem_addr_o( imem_addr )
    , .commit_o( commit )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic compare_field(string name, word_t got, word_t want);
    assert (got === want) else begin
      $display("Error: time %0t, %s is %h, expected %h", $time, name, got, want);
      $display("test failed");
      $fatal(1);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Random program, forward branches only
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic build_program();
    int         pc;
    int         kind;
    int         target;
    reg_addr_t  rd;
    reg_addr_t  rn;
    reg_addr_t  prev_rd;
    word_t      r;
    imm_t       imm;
    logic [3:0] opc;
    pc      = 0;
    prev_rd = '0;
    while (pc < PROG_LEN) begin
      kind = $unsigned($random(seed)) % 12;
      rd   = reg_addr_t'(1 + $unsigned($random(seed)) % 15);    // r0 is never written
      rn   = reg_addr_t'($random(seed));
      r    = $random(seed);
      imm  = r[15:0];
      opc  = (kind < 10) ? 4'(kind) : 4'(10 + r[18:16] % 6);    // Top codes act as NOP
      if ($unsigned($random(seed)) % 3 == 0) begin
        rn = prev_rd;                                           // Back-to-back dependency
      end
      case (opc)
        OP_LDR, OP_STR: begin
          imm = imm_t'(r[3:0]);                                 // Small offsets so addresses meet
        end
        OP_B, OP_BZ: begin
          target = pc + 2 + $unsigned($random(seed)) % 6;
          imm    = imm_t'((target > PROG_LEN) ? PROG_LEN : target);
          if (opc == OP_BZ && r[16]) begin
            rn = '0;                                            // Zero register, so taken
          end
        end
        default: begin
        end
      endcase
      prog[pc] = {opc, rd, rn, r[31:28], imm};
      if (opc >= OP_ADD && opc <= OP_LDR) begin
        prev_rd = rd;
      end
      pc++;
      // Load back what was just stored
      if (opc == OP_STR && pc < PROG_LEN && r[17]) begin
        prev_rd  = (rd == 4'd15) ? 4'd1 : rd + 4'd1;
        prog[pc] = {4'(OP_LDR), prev_rd, rn, r[31:28], imm};
        pc++;
      end
    end
  endtask

  // Sequential model that lists the expected commit records
  task automatic run_model();
    word_t      regs [16];
    word_t      dmem [DMEM_WORDS];
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      wdata;
    word_t      addr;
    logic [3:0] op;
    reg_addr_t  rd;
    commit_t    rec;
    int         pc;
    for (int i = 0; i < 16; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = '0;
    end
    pc = 0;
    while (pc < PROG_LEN) begin
      ins  = prog[pc];
      op   = ins[31:28];
      rd   = ins[27:24];
      a    = regs[ins[23:20]];
      b    = regs[ins[19:16]];
      addr = a + word_t'(ins[15:0]);
      rec  = '0;
      pc   = pc + 1;
      case (op)
        OP_ADD:           wdata = a + b;
        OP_SUB:           wdata = a - b;
        OP_AND:           wdata = a & b;
        OP_ORR:           wdata = a | b;
        OP_ADDI:          wdata = addr;
        OP_LDR:           wdata = dmem[addr % DMEM_WORDS];
        OP_STR:           wdata = regs[rd];
        default:          wdata = '0;
      endcase
      if (op >= OP_ADD && op <= OP_LDR) begin
        rec.reg_we = 1'b1;
        regs[rd]   = wdata;
      end
      if (op == OP_STR) begin
        rec.store               = 1'b1;
        dmem[addr % DMEM_WORDS] = wdata;
      end
      if (rec.reg_we || rec.store) begin
        rec.valid    = 1'b1;
        rec.rd       = rd;
        rec.data     = wdata;
        rec.mem_addr = (op == OP_LDR || op == OP_STR) ? addr : '0;
        exp_q.push_back(rec);
      end
      if (op == OP_B || (op == OP_BZ && a == '0)) begin
        pc = int'(ins[15:0]);
      end
    end
  endtask

  // Instruction memory answers for the PC set at this edge
  always @(posedge clk) begin
    #1;
    imem_data = (int'(imem_addr) < PROG_LEN) ? prog[imem_addr] : '0;
  end

  always @(negedge clk) begin
    if (!rst && commit.valid) begin
      assert (n_seen < n_exp) else begin
        abort_run("A commit record arrived after all expected records");
      end
      exp_rec = exp_q[n_seen];
      compare_field("commit_o.reg_we", commit.reg_we, exp_rec.reg_we);
      compare_field("commit_o.rd", commit.rd, exp_rec.rd);
      compare_field("commit_o.data", commit.data, exp_rec.data);
      compare_field("commit_o.store", commit.store, exp_rec.store);
      compare_field("commit_o.mem_addr", commit.mem_addr, exp_rec.mem_addr);
      n_seen++;
    end
  end

  initial begin
    seed      = 79594;
    rst       = 1'b1;
    imem_data = '0;
    n_seen    = 0;
    build_program();
    run_model();
    n_exp = exp_q.size();
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b0;
    wait (n_seen == n_exp);
    repeat (20) @(posedge clk);              // Room for a stray record
    $display("test passed");
    $finish;
  end

  initial begin
    repeat (RESET_CYCLES + PROG_LEN * 8) @(posedge clk);
    $display("Timeout: only %0d of %0d commit records arrived", n_seen, n_exp);
    $display("test failed");
    $fatal(1);
  end

endmodule

// ==== files.f ====
cpu_pkg.sv
fetch.sv
decode_reg_r.sv
execute.sv
mem.sv
cpu.sv
cpu_assert.sv
cpu_tb.sv
